// File: Bender.yml
package:
  name: sinescroll_fb

sources:
  - design/fb_geom_pkg.sv
  - design/fb_colour_pkg.sv
  - design/bram_sdp.sv
  - design/bitmap_addr.sv
  - design/render_scroll.sv
  - design/fb_draw_ctrl.sv
  - design/fb_readout.sv
  - design/palette_cfg.sv
  - design/sinescroll_fb_top.sv
  - target: test
    files:
      - testbench/fb_assertions.sv
      - testbench/tb_sinescroll_fb.sv

// File: design/bitmap_addr.sv
// bitmap address stage
// coordinates to linear buffer address in three cycles, with an off-screen flag
`default_nettype none
`timescale 1ns/10ps

module bitmap_addr #(
    parameter int FB_WIDTH  = 16,
    parameter int FB_HEIGHT = 8,
    parameter int ADDRW     = 7
) (
    input  wire logic                clk_sys,
    input  wire fb_geom_pkg::coord_t x,
    input  wire fb_geom_pkg::coord_t y,
    output logic [ADDRW-1:0]         addr,
    output logic                     clip
);
    import fb_geom_pkg::*;

    coord_t           x_1, y_1;
    coord_t           x_2;
    logic [ADDRW-1:0] row_2;
    logic             clip_1, clip_2;

    always_ff @(posedge clk_sys) begin
        // stage 1: capture and bounds test
        x_1    <= x;
        y_1    <= y;
        clip_1 <= (x < 0) || (x >= FB_WIDTH) || (y < 0) || (y >= FB_HEIGHT);

        // stage 2: row offset
        row_2  <= ADDRW'(y_1 * FB_WIDTH);
        x_2    <= x_1;
        clip_2 <= clip_1;

        // stage 3: add column
        addr   <= row_2 + ADDRW'(x_2);
        clip   <= clip_2;
    end

endmodule

`default_nettype wire

// File: design/bram_sdp.sv
// simple dual-port block RAM
// one write port, one registered read port with enable
`default_nettype none
`timescale 1ns/10ps

module bram_sdp #(
    parameter int  DEPTH  = 256,
    parameter type data_t = logic [7:0]
) (
    input  wire logic                     clk_sys,
    input  wire logic                     we,
    input  wire logic                     rd_en,
    input  wire logic [$clog2(DEPTH)-1:0] addr_write,
    input  wire logic [$clog2(DEPTH)-1:0] addr_read,
    input  wire data_t                    data_in,
    output data_t                         data_out
);

    data_t mem [DEPTH];

    // start from a cleared memory
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = data_t'(0);
        end
    end

    always_ff @(posedge clk_sys) begin
        if (we) mem[addr_write] <= data_in;
        if (rd_en) data_out <= mem[addr_read];  // holds while disabled
    end

endmodule

`default_nettype wire

// File: design/fb_colour_pkg.sv
// colour definitions
// palette index and 12-bit RGB word shared by buffers, palette and readout
`default_nettype none

package fb_colour_pkg;

    localparam int CIDXW = 4;                   // colour index bits
    typedef logic [CIDXW-1:0] cidx_t;

    localparam int CHANW = 4;                   // bits per channel
    typedef logic [3*CHANW-1:0] colr_t;         // {red, green, blue}, red on top

    localparam int PAL_DEPTH = 2**CIDXW;        // one entry per index

endpackage

`default_nettype wire

// File: design/fb_draw_ctrl.sv
// framebuffer drawing controller
// swaps buffers per frame, clears the back buffer, then writes the rendered line
`default_nettype none
`timescale 1ns/10ps

module fb_draw_ctrl #(
    parameter int                   FB_WIDTH  = 16,
    parameter int                   FB_HEIGHT = 8,
    parameter fb_colour_pkg::cidx_t DRAW_CIDX = 4'hf
) (
    input  wire logic                                clk_sys,
    input  wire logic                                rst_sys,
    input  wire logic                                frame_start,
    output logic                                     draw_busy,
    output logic                                     fb_front,
    output logic                                     fb_we,
    output logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0]    fb_addr_write,
    output fb_colour_pkg::cidx_t                     fb_cidx_write
);
    import fb_geom_pkg::*;
    import fb_colour_pkg::*;

    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int ADDRW     = $clog2(FB_PIXELS);
    localparam int LAT_ADDR  = 3;  // bitmap_addr latency

    typedef enum logic [2:0] {IDLE, INIT, CLEAR, DRAW, DONE} state_t;

    state_t              state;
    logic                render_start, render_done;
    logic                drawing, clip;
    coord_t              drx, dry;
    logic [ADDRW-1:0]    addr_render, addr_clear;
    logic [LAT_ADDR-1:0] we_sr;

    assign draw_busy = (state != IDLE);

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            state        <= IDLE;
            fb_front     <= 1'b0;
            render_start <= 1'b0;
        end else begin
            case (state)
                IDLE:  if (frame_start) state <= INIT;  // later pulses ignored
                INIT: begin
                    fb_front <= ~fb_front;  // swap
                    state    <= CLEAR;
                end
                CLEAR: begin
                    if (addr_clear == ADDRW'(FB_PIXELS-1)) begin
                        state        <= DRAW;
                        render_start <= 1'b1;
                    end
                end
                DRAW: begin
                    render_start <= 1'b0;
                    if (render_done) state <= DONE;
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // clear sweep address
    always_ff @(posedge clk_sys) begin
        if (state == INIT) addr_clear <= '0;
        else if (state == CLEAR) addr_clear <= addr_clear + 1'b1;
    end

    render_scroll #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) render_inst (
        .clk_sys,
        .rst_sys,
        .start   (render_start),
        .x       (drx),
        .y       (dry),
        .drawing,
        .done    (render_done)
    );

    bitmap_addr #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT),
        .ADDRW     (ADDRW)
    ) addr_inst (
        .clk_sys,
        .x    (drx),
        .y    (dry),
        .addr (addr_render),
        .clip
    );

    // write enable follows the address stage, clipped points dropped
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            we_sr <= '0;
            fb_we <= 1'b0;
        end else begin
            we_sr <= {drawing, we_sr[LAT_ADDR-1:1]};
            fb_we <= (state == CLEAR) || (we_sr[0] && !clip);
        end
    end

    always_ff @(posedge clk_sys) begin
        fb_addr_write <= (state == CLEAR) ? addr_clear : addr_render;
        fb_cidx_write <= (state == CLEAR) ? cidx_t'(0) : DRAW_CIDX;  // index 0 clears
    end

endmodule

`default_nettype wire

// File: design/fb_geom_pkg.sv
// framebuffer geometry
// buffer size defaults, coordinate width and the clip margin of the renderer
`default_nettype none

package fb_geom_pkg;

    // default buffer size in pixels
    localparam int FB_WIDTH_DEF  = 16;
    localparam int FB_HEIGHT_DEF = 8;

    // signed drawing coordinates
    localparam int CORDW = 8;
    typedef logic signed [CORDW-1:0] coord_t;

    // columns drawn past each side of the buffer
    localparam int CLIP_MARGIN = 2;

endpackage

`default_nettype wire

// File: design/fb_readout.sv
// front buffer readout
// raster scan through the palette into a valid/ready pixel stream with skid
`default_nettype none
`timescale 1ns/10ps

module fb_readout #(
    parameter int FB_WIDTH  = 16,
    parameter int FB_HEIGHT = 8
) (
    input  wire logic                             clk_sys,
    input  wire logic                             rst_sys,
    input  wire logic                             fb_front,
    output logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0] fb_addr_read,
    input  wire fb_colour_pkg::cidx_t             fb_cidx_read_0,
    input  wire fb_colour_pkg::cidx_t             fb_cidx_read_1,
    output logic                                  fb_rd_en,
    output logic                                  pal_rd_en,
    output fb_colour_pkg::cidx_t                  pal_idx,
    input  wire fb_colour_pkg::colr_t             pal_colr,
    output logic                                  pix_valid,
    input  wire logic                             pix_ready,
    output fb_colour_pkg::colr_t                  pix_colr,
    output logic                                  pix_sof
);
    import fb_colour_pkg::*;

    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int ADDRW     = $clog2(FB_PIXELS);

    logic  adv;                    // pipeline advances
    logic  out_free;               // output register can load
    logic  vld_1, sof_1, sel_1;    // after RAM read
    logic  vld_2, sof_2;           // after palette read
    logic  skid_vld, skid_sof;
    colr_t skid_colr;

    assign adv       = !skid_vld;
    assign fb_rd_en  = adv;
    assign pal_rd_en = adv;
    assign out_free  = !pix_valid || pix_ready;

    // buffer chosen at start of buffer, held for the whole scan
    assign pal_idx = sel_1 ? fb_cidx_read_1 : fb_cidx_read_0;

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            fb_addr_read <= '0;
            vld_1        <= 1'b0;
            vld_2        <= 1'b0;
            sel_1        <= 1'b0;
        end else if (adv) begin
            fb_addr_read <= (fb_addr_read == ADDRW'(FB_PIXELS-1)) ? '0 : fb_addr_read + 1'b1;
            vld_1        <= 1'b1;
            vld_2        <= vld_1;
            if (fb_addr_read == '0) sel_1 <= fb_front;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (adv) begin
            sof_1 <= (fb_addr_read == '0);
            sof_2 <= sof_1;
        end
    end

    // output register plus one skid entry
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            pix_valid <= 1'b0;
            skid_vld  <= 1'b0;
        end else if (out_free) begin
            pix_valid <= skid_vld || vld_2;
            skid_vld  <= 1'b0;
        end else if (adv && vld_2) begin
            skid_vld <= 1'b1;  // in-flight pixel parked
        end
    end

    always_ff @(posedge clk_sys) begin
        if (out_free) begin
            pix_colr <= skid_vld ? skid_colr : pal_colr;
            pix_sof  <= skid_vld ? skid_sof : sof_2;
        end else if (adv && vld_2) begin
            skid_colr <= pal_colr;
            skid_sof  <= sof_2;
        end
    end

endmodule

`default_nettype wire

// File: design/palette_cfg.sv
// palette configuration
// host write port with handshake, palette RAM read by the readout
`default_nettype none
`timescale 1ns/10ps

module palette_cfg (
    input  wire logic                 clk_sys,
    input  wire logic                 rst_sys,
    input  wire logic                 cfg_valid,
    output logic                      cfg_ready,
    input  wire fb_colour_pkg::cidx_t cfg_idx,
    input  wire fb_colour_pkg::colr_t cfg_colr,
    input  wire logic                 pal_rd_en,
    input  wire fb_colour_pkg::cidx_t pal_idx,
    output fb_colour_pkg::colr_t      pal_colr
);
    import fb_colour_pkg::*;

    logic  wr_en;
    cidx_t wr_idx;
    colr_t wr_colr;

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            cfg_ready <= 1'b0;
            wr_en     <= 1'b0;
        end else begin
            cfg_ready <= 1'b1;                   // always accepts once out of reset
            wr_en     <= cfg_valid && cfg_ready;
        end
    end

    // registered write request
    always_ff @(posedge clk_sys) begin
        if (cfg_valid && cfg_ready) begin
            wr_idx  <= cfg_idx;
            wr_colr <= cfg_colr;
        end
    end

    bram_sdp #(
        .DEPTH  (PAL_DEPTH),
        .data_t (colr_t)
    ) pal_mem (
        .clk_sys,
        .we         (wr_en),
        .rd_en      (pal_rd_en),
        .addr_write (wr_idx),
        .addr_read  (pal_idx),
        .data_in    (wr_colr),
        .data_out   (pal_colr)
    );

endmodule

`default_nettype wire

// File: design/render_scroll.sv
// scrolling diagonal renderer
// one point per column, line moves down a row each frame
`default_nettype none
`timescale 1ns/10ps

module render_scroll #(
    parameter int FB_WIDTH  = 16,
    parameter int FB_HEIGHT = 8
) (
    input  wire logic          clk_sys,
    input  wire logic          rst_sys,
    input  wire logic          start,
    output fb_geom_pkg::coord_t x,
    output fb_geom_pkg::coord_t y,
    output logic               drawing,
    output logic               done
);
    import fb_geom_pkg::*;

    localparam int NPTS       = FB_WIDTH + 2*CLIP_MARGIN;  // columns incl. margins
    localparam int CNTW       = $clog2(NPTS);
    localparam int MARGIN_MOD = CLIP_MARGIN % FB_HEIGHT;

    logic [CNTW-1:0] cnt;
    coord_t          phase;
    coord_t          y_first;
    int              y_sum;

    // row of the first column, (phase - margin) mod height
    always_comb begin
        y_sum = int'(phase) + FB_HEIGHT - MARGIN_MOD;
        if (y_sum >= FB_HEIGHT) y_sum = y_sum - FB_HEIGHT;
        y_first = coord_t'(y_sum);
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            drawing <= 1'b0;
            done    <= 1'b0;
            phase   <= '0;
            cnt     <= '0;
        end else begin
            done <= 1'b0;
            if (start && !drawing) begin
                drawing <= 1'b1;
                cnt     <= '0;
                x       <= coord_t'(-CLIP_MARGIN);
                y       <= y_first;
            end else if (drawing) begin
                cnt <= cnt + 1'b1;
                x   <= x + coord_t'(1);
                y   <= (y == coord_t'(FB_HEIGHT-1)) ? '0 : y + coord_t'(1);  // wrap row
                if (cnt == CNTW'(NPTS-1)) begin
                    drawing <= 1'b0;
                    done    <= 1'b1;
                    phase   <= (phase == coord_t'(FB_HEIGHT-1)) ? '0 : phase + coord_t'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/sinescroll_fb_top.sv
// double-buffered framebuffer subsystem
// draw controller, two index buffers, palette and stallable pixel readout
`default_nettype none
`timescale 1ns/10ps

module sinescroll_fb_top #(
    parameter int                   FB_WIDTH  = fb_geom_pkg::FB_WIDTH_DEF,
    parameter int                   FB_HEIGHT = fb_geom_pkg::FB_HEIGHT_DEF,
    parameter fb_colour_pkg::cidx_t DRAW_CIDX =
        fb_colour_pkg::cidx_t'(fb_colour_pkg::PAL_DEPTH - 1)
) (
    input  wire logic                 clk_sys,
    input  wire logic                 rst_sys,
    input  wire logic                 frame_start,
    input  wire logic                 cfg_valid,
    output logic                      cfg_ready,
    input  wire fb_colour_pkg::cidx_t cfg_idx,
    input  wire fb_colour_pkg::colr_t cfg_colr,
    output logic                      pix_valid,
    input  wire logic                 pix_ready,
    output fb_colour_pkg::colr_t      pix_colr,
    output logic                      pix_sof,
    output logic                      draw_busy
);
    import fb_colour_pkg::*;

    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int FB_ADDRW  = $clog2(FB_PIXELS);

    logic                fb_front, fb_we, fb_rd_en, pal_rd_en;
    logic [FB_ADDRW-1:0] fb_addr_write, fb_addr_read;
    cidx_t               fb_cidx_write, fb_cidx_read_0, fb_cidx_read_1;
    cidx_t               pal_idx;
    colr_t               pal_colr;

    fb_draw_ctrl #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT),
        .DRAW_CIDX (DRAW_CIDX)
    ) draw_inst (
        .clk_sys, .rst_sys, .frame_start, .draw_busy,
        .fb_front, .fb_we, .fb_addr_write, .fb_cidx_write
    );

    // buffer 1 is shown while fb_front is high, so buffer 0 takes the writes
    bram_sdp #(.DEPTH(FB_PIXELS), .data_t(cidx_t)) fb_mem_0 (
        .clk_sys,
        .we         (fb_we && fb_front),
        .rd_en      (fb_rd_en),
        .addr_write (fb_addr_write),
        .addr_read  (fb_addr_read),
        .data_in    (fb_cidx_write),
        .data_out   (fb_cidx_read_0)
    );

    bram_sdp #(.DEPTH(FB_PIXELS), .data_t(cidx_t)) fb_mem_1 (
        .clk_sys,
        .we         (fb_we && !fb_front),
        .rd_en      (fb_rd_en),
        .addr_write (fb_addr_write),
        .addr_read  (fb_addr_read),
        .data_in    (fb_cidx_write),
        .data_out   (fb_cidx_read_1)
    );

    palette_cfg pal_inst (
        .clk_sys, .rst_sys, .cfg_valid, .cfg_ready, .cfg_idx, .cfg_colr,
        .pal_rd_en, .pal_idx, .pal_colr
    );

    fb_readout #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) readout_inst (
        .clk_sys, .rst_sys, .fb_front, .fb_addr_read,
        .fb_cidx_read_0, .fb_cidx_read_1, .fb_rd_en,
        .pal_rd_en, .pal_idx, .pal_colr,
        .pix_valid, .pix_ready, .pix_colr, .pix_sof
    );

endmodule

`default_nettype wire

// File: sinescroll_fb.f
design/fb_geom_pkg.sv
design/fb_colour_pkg.sv
design/bram_sdp.sv
design/bitmap_addr.sv
design/render_scroll.sv
design/fb_draw_ctrl.sv
design/fb_readout.sv
design/palette_cfg.sv
design/sinescroll_fb_top.sv
testbench/fb_assertions.sv
testbench/tb_sinescroll_fb.sv

// File: testbench/fb_assertions.sv
// framebuffer protocol assertions
// stream hold under back-pressure and the buffer swap rules
`default_nettype none
`timescale 1ns/10ps

module fb_assertions #(
    parameter bit STREAM_SIDE = 1'b0  // 1 checks the pixel stream, 0 the buffer swap
) (
    input wire logic                 clk_sys,
    input wire logic                 rst_sys,
    input wire logic                 draw_busy,
    input wire logic                 fb_front,
    input wire logic                 fb_we,
    input wire logic                 pix_valid,
    input wire logic                 pix_ready,
    input wire fb_colour_pkg::colr_t pix_colr,
    input wire logic                 pix_sof
);

    int err_count = 0;  // failures so far

    if (STREAM_SIDE) begin : stream_checks
        // stalled pixel stays put until taken
        stream_hold: assert property (@(posedge clk_sys) disable iff (rst_sys)
            pix_valid && !pix_ready |=> pix_valid && $stable(pix_colr) && $stable(pix_sof))
        else begin
            err_count++;
            $error("pixel stream changed while stalled");
        end
    end else begin : buffer_checks
        // a write never lands in the swap cycle, so it stays in the back buffer
        write_back_only: assert property (@(posedge clk_sys) disable iff (rst_sys)
            fb_we |-> $stable(fb_front))
        else begin
            err_count++;
            $error("buffer write in the cycle of a swap");
        end

        swap_when_busy: assert property (@(posedge clk_sys) disable iff (rst_sys)
            $changed(fb_front) |-> draw_busy)
        else begin
            err_count++;
            $error("buffer swap outside a drawing frame");
        end
    end

endmodule

bind fb_draw_ctrl fb_assertions #(.STREAM_SIDE(1'b0)) draw_chk (
    .clk_sys, .rst_sys, .draw_busy, .fb_front, .fb_we,
    .pix_valid (1'b0), .pix_ready (1'b1), .pix_colr ('0), .pix_sof (1'b0)
);

bind fb_readout fb_assertions #(.STREAM_SIDE(1'b1)) stream_chk (
    .clk_sys, .rst_sys, .draw_busy (1'b0), .fb_front (1'b0), .fb_we (1'b0),
    .pix_valid, .pix_ready, .pix_colr, .pix_sof
);

`default_nettype wire

// File: testbench/fb_input.txt
# columns: pal <index hex> <rgb hex> | seed <decimal> | frame <ready> <extra pulse> <phase>
# ready 1 keeps pix_ready high, 0 uses xorshift; phase is the line shown, -1 a cleared buffer
# palette, entry f is the line colour and entry 0 the background
pal 0 000
pal 1 00f
pal f 0f0
pal 7 f80
pal f fff
pal 0 102
# xorshift seed for pix_ready
seed 76
# first swap shows the never drawn buffer
frame 1 0 -1
# drawn frames, steady receiver
frame 1 0 0
frame 1 0 1
# drawn frames with back-pressure
frame 0 0 2
# second pulse while busy, next frame must still show phase 4
frame 0 1 3
frame 0 0 4
frame 1 0 5

// File: testbench/tb_sinescroll_fb.sv
// testbench for the double-buffered framebuffer subsystem
// palette load, frame commands and full-buffer pixel checks from a stimulus file
`default_nettype none
`timescale 1ns/10ps

module tb_sinescroll_fb;
    import fb_geom_pkg::*;
    import fb_colour_pkg::*;

    localparam int    FB_WIDTH   = FB_WIDTH_DEF;
    localparam int    FB_HEIGHT  = FB_HEIGHT_DEF;
    localparam int    FB_PIXELS  = FB_WIDTH * FB_HEIGHT;
    localparam cidx_t DRAW_CIDX  = cidx_t'(PAL_DEPTH - 1);
    localparam int    BUSY_LIMIT = 4 * FB_PIXELS;  // well above one frame in cycles
    localparam int    XFER_LIMIT = 64;             // cycles between two transfers

    logic  clk_sys, rst_sys, frame_start;
    logic  cfg_valid, cfg_ready;
    cidx_t cfg_idx;
    colr_t cfg_colr;
    logic  pix_valid, pix_ready, pix_sof;
    colr_t pix_colr;
    logic  draw_busy;

    colr_t       pal_model [PAL_DEPTH];  // palette as loaded by the host
    logic [31:0] rng;
    logic        stall_mode;             // random pix_ready when set
    int          drawn_phase;            // phase in the back buffer or -1 when cleared
    int          next_phase;

    sinescroll_fb_top #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT),
        .DRAW_CIDX (DRAW_CIDX)
    ) DUT (
        .clk_sys, .rst_sys, .frame_start,
        .cfg_valid, .cfg_ready, .cfg_idx, .cfg_colr,
        .pix_valid, .pix_ready, .pix_colr, .pix_sof,
        .draw_busy
    );

    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // receiver that stalls at random in stall mode
    initial begin
        forever begin
            @(posedge clk_sys);
            if (stall_mode) begin
                rng = xorshift32(rng);
                pix_ready <= rng[0];
            end else begin
                pix_ready <= 1'b1;
            end
        end
    end

    always @(posedge clk_sys) begin
        if (DUT.draw_inst.draw_chk.err_count + DUT.readout_inst.stream_chk.err_count != 0) begin
            $display("ERROR: a concurrent assertion failed");
            $display("SIMULATION FAILED");
            $fatal(1, "assertion failure");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string what);
        $display("ERROR: %s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic write_palette(input cidx_t idx, input colr_t colr);
        int cyc;
        cyc = 0;
        @(posedge clk_sys);
        cfg_valid <= 1'b1;
        cfg_idx   <= idx;
        cfg_colr  <= colr;
        @(negedge clk_sys);
        while (!cfg_ready) begin
            cyc++;
            if (cyc > XFER_LIMIT) abort_run("palette write was never accepted");
            @(negedge clk_sys);
        end
        @(posedge clk_sys);  // transfer edge
        cfg_valid <= 1'b0;
        pal_model[idx] = colr;
    endtask

    task automatic pulse_frame();
        @(posedge clk_sys);
        frame_start <= 1'b1;
        @(posedge clk_sys);
        frame_start <= 1'b0;
    endtask

    task automatic wait_busy(input logic level, input string what);
        int cyc;
        cyc = 0;
        @(negedge clk_sys);
        while (draw_busy !== level) begin
            cyc++;
            if (cyc > BUSY_LIMIT) abort_run(what);
            @(negedge clk_sys);
        end
    endtask

    // sampled at the falling edge before the transfer edge
    task automatic next_transfer(output colr_t colr, output logic sof);
        int cyc;
        cyc = 0;
        @(negedge clk_sys);
        while (!(pix_valid && pix_ready)) begin
            cyc++;
            if (cyc > XFER_LIMIT) abort_run("no pixel transfer on the output stream");
            @(negedge clk_sys);
        end
        colr = pix_colr;
        sof  = pix_sof;
    endtask

    function automatic colr_t expected_colr(input int x, input int y, input int shown);
        if (shown >= 0 && y == (x + shown) % FB_HEIGHT) return pal_model[DRAW_CIDX];
        return pal_model[0];
    endfunction

    task automatic check_buffer(input int shown);
        colr_t colr;
        logic  sof;
        int    skipped;
        skipped = 0;
        next_transfer(colr, sof);
        while (!sof) begin
            skipped++;
            if (skipped > 2 * FB_PIXELS) abort_run("no pix_sof seen within two buffers");
            next_transfer(colr, sof);
        end
        for (int i = 0; i < FB_PIXELS; i++) begin
            if (i > 0) next_transfer(colr, sof);
            check_value("pix_sof", sof, (i == 0));
            check_value($sformatf("pix_colr at x %0d y %0d", i % FB_WIDTH, i / FB_WIDTH),
                        colr, expected_colr(i % FB_WIDTH, i / FB_WIDTH, shown));
        end
        next_transfer(colr, sof);
        check_value("pix_sof after one buffer", sof, 1'b1);
    endtask

    initial begin
        string          tok;
        reg [8*160-1:0] line_buf;
        int             fd, n, a, b, c, shown;

        rst_sys     = 1'b1;
        frame_start = 1'b0;
        cfg_valid   = 1'b0;
        cfg_idx     = '0;
        cfg_colr    = '0;
        pix_ready   = 1'b1;
        stall_mode  = 1'b0;
        rng         = '0;
        drawn_phase = -1;
        next_phase  = 0;
        for (int i = 0; i < PAL_DEPTH; i++) pal_model[i] = '0;  // RAM starts cleared

        fd = $fopen("testbench/fb_input.txt", "r");
        if (fd == 0) abort_run("cannot open testbench/fb_input.txt");

        repeat (8) @(posedge clk_sys);
        @(negedge clk_sys);
        check_value("cfg_ready in reset", cfg_ready, 1'b0);
        repeat (8) @(posedge clk_sys);
        rst_sys <= 1'b0;

        wait_busy(1'b0, "draw_busy stuck high after reset");
        while (!cfg_ready) begin
            a++;
            if (a > XFER_LIMIT) abort_run("cfg_ready never rose after reset");
            @(negedge clk_sys);
        end

        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", tok);
            if (n == 1) begin
                if (tok == "#") begin
                    n = $fgets(line_buf, fd);  // rest of comment line
                end else if (tok == "pal") begin
                    n = $fscanf(fd, "%h %h", a, b);
                    write_palette(cidx_t'(a), colr_t'(b));
                end else if (tok == "seed") begin
                    n = $fscanf(fd, "%d", a);
                    rng = a;
                end else if (tok == "frame") begin
                    n = $fscanf(fd, "%d %d %d", a, b, c);
                    @(negedge clk_sys);
                    stall_mode = (a == 0);
                    pulse_frame();
                    wait_busy(1'b1, "draw_busy did not rise after frame_start");
                    if (b != 0) pulse_frame();  // must be ignored while busy
                    wait_busy(1'b0, "draw_busy did not fall after the frame");
                    shown       = drawn_phase;
                    drawn_phase = next_phase;
                    next_phase  = (next_phase + 1) % FB_HEIGHT;
                    check_value("expected phase", shown, c);
                    check_buffer(shown);
                end else begin
                    abort_run($sformatf("unknown command %s in stimulus file", tok));
                end
            end
        end
        $fclose(fd);

        if (DUT.draw_inst.draw_chk.err_count + DUT.readout_inst.stream_chk.err_count != 0) begin
            $display("ERROR: concurrent assertions failed during the run");
            $display("SIMULATION FAILED");
            $fatal(1, "assertion failures");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
